/* source/mpmc_wb_pkg.sv */
`default_nettype none

// ==============================
// channel side definitions
// ==============================

package mpmc_wb_pkg;

	localparam int NUM_CH = 4;
	localparam int ADR_W  = 32;
	localparam int DATA_W = 128;
	localparam int SEL_W  = 16;

	typedef logic [1:0] ch_id_t;

	// one Wishbone classic request as seen on a channel port
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADR_W-1:0]  adr;
		logic [SEL_W-1:0]  sel;
		logic [DATA_W-1:0] dat;
	} wb_req_t;

	// response back to the master
	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] dat;
	} wb_resp_t;

	// request word held in the queue, tagged with its channel
	typedef struct packed {
		logic              stb;
		logic              we;
		logic [ADR_W-1:0]  adr;
		logic [SEL_W-1:0]  sel;
		logic [DATA_W-1:0] dat;
		ch_id_t            cid;
	} req_entry_t;

endpackage

`default_nettype wire

/* source/mpmc_app_pkg.sv */
`default_nettype none

// ==============================
// memory side definitions
// ==============================

package mpmc_app_pkg;

	localparam int APP_ADR_W  = 29;
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AFULL = 6;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	// opcodes as used on the DDR user interface
	typedef enum logic [2:0] {
		APP_WRITE = 3'd0,
		APP_READ  = 3'd1
	} app_cmd_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CMD,
		ST_WDATA,
		ST_RWAIT
	} seq_state_e;

	// command port
	typedef struct packed {
		logic                 en;
		app_cmd_e             cmd;
		logic [APP_ADR_W-1:0] addr;
	} app_req_t;

	// write data port, last is the strip end flag
	typedef struct packed {
		logic                             wren;
		logic                             last;
		logic [mpmc_wb_pkg::DATA_W-1:0]   data;
		logic [mpmc_wb_pkg::SEL_W-1:0]    mask;
	} app_wdf_t;

	// one finished request on its way back to a channel
	typedef struct packed {
		logic                           valid;
		mpmc_wb_pkg::ch_id_t            cid;
		logic [mpmc_wb_pkg::DATA_W-1:0] data;
	} cpl_t;

endpackage

`default_nettype wire

/* source/mpmc_req_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module mpmc_req_arbiter import mpmc_wb_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  wb_req_t    ch_req [NUM_CH],
	input  logic       almost_full,
	output logic       push,
	output req_entry_t entry
);

	logic [NUM_CH-1:0] stb_now;
	logic [NUM_CH-1:0] stb_q;
	logic [NUM_CH-1:0] rise;
	logic [NUM_CH-1:0] pending;
	ch_id_t            last_ch;
	ch_id_t            gnt_ch;
	logic              gnt_valid;

	// ==============================
	// new request detection
	// ==============================

	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			stb_now[i] = ch_req[i].cyc & ch_req[i].stb;
		end
	end

	// a strobe counts once, on its rising edge
	assign rise = stb_now & ~stb_q;

	// ==============================
	// round robin select
	// ==============================

	// search starts one past the last channel granted
	always_comb begin
		ch_id_t idx;
		gnt_valid = 1'b0;
		gnt_ch = last_ch;
		for (int k = 1; k <= NUM_CH; k++) begin
			idx = ch_id_t'((last_ch + k) % NUM_CH);
			if (!gnt_valid && pending[idx]) begin
				gnt_valid = 1'b1;
				gnt_ch = idx;
			end
		end
		// hold everything off while the queue is close to full
		if (almost_full)
			gnt_valid = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stb_q <= '0;
			pending <= '0;
			last_ch <= ch_id_t'(NUM_CH - 1);
			push <= 1'b0;
		end else begin
			stb_q <= stb_now;
			push <= gnt_valid;
			if (gnt_valid)
				last_ch <= gnt_ch;
			for (int i = 0; i < NUM_CH; i++) begin
				if (rise[i])
					pending[i] <= 1'b1;
				else if (gnt_valid && gnt_ch == ch_id_t'(i))
					pending[i] <= 1'b0;
			end
		end
	end

	// tagged copy of the granted request
	always_ff @(posedge clk) begin
		if (gnt_valid) begin
			entry.stb <= ch_req[gnt_ch].stb;
			entry.we <= ch_req[gnt_ch].we;
			entry.adr <= ch_req[gnt_ch].adr;
			entry.sel <= ch_req[gnt_ch].sel;
			entry.dat <= ch_req[gnt_ch].dat;
			entry.cid <= gnt_ch;
		end
	end

endmodule

`default_nettype wire

/* source/mpmc_req_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module mpmc_req_fifo import mpmc_wb_pkg::*, mpmc_app_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       push,
	input  logic       pop,
	input  req_entry_t din,
	output req_entry_t dout,
	output logic       not_empty,
	output logic       almost_full
);

	req_entry_t            mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	// a push into a full queue is dropped
	assign do_push = push && (count != FIFO_CNT_W'(FIFO_DEPTH));
	assign do_pop  = pop && not_empty;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head is shown straight from the buffer
	assign dout        = mem[rd_ptr];
	assign not_empty   = (count != '0);
	assign almost_full = (count >= FIFO_CNT_W'(FIFO_AFULL));

endmodule

`default_nettype wire

/* source/mpmc_mem_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module mpmc_mem_sequencer import mpmc_wb_pkg::*, mpmc_app_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  req_entry_t        head,
	input  logic              not_empty,
	output logic              pop,
	input  logic              app_rdy,
	input  logic              app_wdf_rdy,
	input  logic              app_rd_data_valid,
	input  logic [DATA_W-1:0] app_rd_data,
	output app_req_t          cmd,
	output app_wdf_t          wdf,
	output cpl_t              cpl
);

	seq_state_e        state;
	req_entry_t        cur;
	logic [DATA_W-1:0] wr_data;
	logic [DATA_W-1:0] rd_data_q;
	logic              rd_done_q;
	logic              wr_done;

	// ==============================
	// request sequencing
	// ==============================

	assign pop = (state == ST_IDLE) && not_empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			rd_done_q <= 1'b0;
		end else begin
			rd_done_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (not_empty)
						state <= ST_CMD;
				end
				ST_CMD: begin
					// stays here with en held until the controller takes it
					if (app_rdy)
						state <= cur.we ? ST_WDATA : ST_RWAIT;
				end
				ST_WDATA: begin
					if (app_wdf_rdy)
						state <= ST_IDLE;
				end
				ST_RWAIT: begin
					if (app_rd_data_valid) begin
						state <= ST_IDLE;
						rd_done_q <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// popped entry stays put until the next pop
	always_ff @(posedge clk) begin
		if (pop)
			cur <= head;
	end

	// only one read is outstanding, so a single register is enough
	always_ff @(posedge clk) begin
		if (state == ST_RWAIT && app_rd_data_valid)
			rd_data_q <= app_rd_data;
	end

	// ==============================
	// memory port
	// ==============================

	// byte lanes without a select go out as ff
	always_comb begin
		for (int b = 0; b < SEL_W; b++) begin
			wr_data[b*8 +: 8] = cur.sel[b] ? cur.dat[b*8 +: 8] : 8'hff;
		end
	end

	assign cmd.en   = (state == ST_CMD);
	assign cmd.cmd  = cur.we ? APP_WRITE : APP_READ;
	assign cmd.addr = APP_ADR_W'({cur.adr[ADR_W-1:4], 4'b0000});

	// single strip, so end goes with every write
	assign wdf.wren = (state == ST_WDATA);
	assign wdf.last = (state == ST_WDATA);
	assign wdf.data = wr_data;
	assign wdf.mask = ~cur.sel;

	// ==============================
	// completion
	// ==============================

	assign wr_done = (state == ST_WDATA) && app_wdf_rdy;

	// write completes as the data is taken, read one cycle after the data returns
	assign cpl.valid = wr_done | rd_done_q;
	assign cpl.cid   = cur.cid;
	assign cpl.data  = wr_done ? wr_data : rd_data_q;

endmodule

`default_nettype wire

/* source/mpmc_resp_router.sv */
`timescale 1ns/1ns
`default_nettype none

module mpmc_resp_router import mpmc_wb_pkg::*, mpmc_app_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  cpl_t     cpl,
	output wb_resp_t ch_resp [NUM_CH]
);

	logic [NUM_CH-1:0] hit;
	logic [NUM_CH-1:0] ack_q;
	logic [DATA_W-1:0] dat_q [NUM_CH];

	// channel decode of the completion tag
	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			hit[i] = cpl.valid && (cpl.cid == ch_id_t'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			ack_q <= '0;
		else
			ack_q <= hit;
	end

	// each channel keeps its own copy so dat holds between acks
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_CH; i++) begin
			if (hit[i])
				dat_q[i] <= cpl.data;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			ch_resp[i].ack = ack_q[i];
			ch_resp[i].dat = dat_q[i];
		end
	end

endmodule

`default_nettype wire

/* source/mpmc_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mpmc_top import mpmc_wb_pkg::*, mpmc_app_pkg::*; (
	input  logic                 mem_ui_clk,
	input  logic                 rst,
	input  wb_req_t              ch_req [NUM_CH],
	output wb_resp_t             ch_resp [NUM_CH],
	input  logic                 app_rdy,
	input  logic                 app_wdf_rdy,
	input  logic                 app_rd_data_valid,
	input  logic [DATA_W-1:0]    app_rd_data,
	output logic                 app_en,
	output logic                 app_wdf_wren,
	output logic                 app_wdf_end,
	output app_cmd_e             app_cmd,
	output logic [APP_ADR_W-1:0] app_addr,
	output logic [DATA_W-1:0]    app_wdf_data,
	output logic [SEL_W-1:0]     app_wdf_mask
);

	req_entry_t arb_entry;
	req_entry_t fifo_head;
	logic       arb_push;
	logic       fifo_afull;
	logic       fifo_not_empty;
	logic       seq_pop;
	app_req_t   cmd_s;
	app_wdf_t   wdf_s;
	cpl_t       cpl_s;

	mpmc_req_arbiter u_arb (
		.clk(mem_ui_clk),
		.rst(rst),
		.ch_req(ch_req),
		.almost_full(fifo_afull),
		.push(arb_push),
		.entry(arb_entry)
	);

	mpmc_req_fifo u_fifo (
		.clk(mem_ui_clk),
		.rst(rst),
		.push(arb_push),
		.pop(seq_pop),
		.din(arb_entry),
		.dout(fifo_head),
		.not_empty(fifo_not_empty),
		.almost_full(fifo_afull)
	);

	mpmc_mem_sequencer u_seq (
		.clk(mem_ui_clk),
		.rst(rst),
		.head(fifo_head),
		.not_empty(fifo_not_empty),
		.pop(seq_pop),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data),
		.cmd(cmd_s),
		.wdf(wdf_s),
		.cpl(cpl_s)
	);

	mpmc_resp_router u_router (
		.clk(mem_ui_clk),
		.rst(rst),
		.cpl(cpl_s),
		.ch_resp(ch_resp)
	);

	// memory port pins
	assign app_en       = cmd_s.en;
	assign app_cmd      = cmd_s.cmd;
	assign app_addr     = cmd_s.addr;
	assign app_wdf_wren = wdf_s.wren;
	assign app_wdf_end  = wdf_s.last;
	assign app_wdf_data = wdf_s.data;
	assign app_wdf_mask = wdf_s.mask;

endmodule

`default_nettype wire

/* tests/mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_model import mpmc_wb_pkg::*, mpmc_app_pkg::*; (
	input  logic                 mem_ui_clk,
	input  logic                 rst,
	input  logic                 app_en,
	input  app_cmd_e             app_cmd,
	input  logic [APP_ADR_W-1:0] app_addr,
	input  logic                 app_wdf_wren,
	input  logic                 app_wdf_end,
	input  logic [DATA_W-1:0]    app_wdf_data,
	input  logic [SEL_W-1:0]     app_wdf_mask,
	output logic                 app_rdy,
	output logic                 app_wdf_rdy,
	output logic                 app_rd_data_valid,
	output logic [DATA_W-1:0]    app_rd_data
);

	logic [DATA_W-1:0]    store [logic [APP_ADR_W-1:0]];
	logic [APP_ADR_W-1:0] wr_addr_q [$];
	logic [DATA_W-1:0]    rd_word;
	logic                 rd_start;
	int                   rd_wait;

	// unwritten locations read as zero
	function automatic logic [DATA_W-1:0] peek(input logic [APP_ADR_W-1:0] a);
		return store.exists(a) ? store[a] : '0;
	endfunction

	// command and write data are taken on the rising edge
	always @(posedge mem_ui_clk) begin
		logic [DATA_W-1:0] w;
		if (!rst && app_en && app_rdy) begin
			if (app_cmd == APP_WRITE) begin
				wr_addr_q.push_back(app_addr);
			end else begin
				rd_word = peek(app_addr);
				rd_start = 1'b1;
			end
		end
		// only lanes with a clear mask bit are written
		if (!rst && app_wdf_wren && app_wdf_end && app_wdf_rdy && wr_addr_q.size() > 0) begin
			w = peek(wr_addr_q[0]);
			for (int b = 0; b < SEL_W; b++) begin
				if (!app_wdf_mask[b])
					w[b*8 +: 8] = app_wdf_data[b*8 +: 8];
			end
			store[wr_addr_q.pop_front()] = w;
		end
	end

	// ready stalls, read latency and the read return change between rising edges
	initial begin
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data_valid = 1'b0;
		app_rd_data = '0;
		rd_word = '0;
		rd_start = 1'b0;
		rd_wait = 0;
		void'($urandom(32'hf6c1_3eb3));
		forever begin
			@(negedge mem_ui_clk);
			app_rd_data_valid <= 1'b0;
			if (rst) begin
				app_rdy <= 1'b0;
				app_wdf_rdy <= 1'b0;
			end else begin
				app_rdy <= ($urandom % 4) != 0;
				app_wdf_rdy <= ($urandom % 4) != 0;
			end
			if (rd_start) begin
				rd_start = 1'b0;
				rd_wait = 2 + int'($urandom % 5);
			end
			if (rd_wait > 0) begin
				rd_wait = rd_wait - 1;
				if (rd_wait == 0) begin
					app_rd_data_valid <= 1'b1;
					app_rd_data <= rd_word;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tests/mpmc_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mpmc_tb import mpmc_wb_pkg::*, mpmc_app_pkg::*; ();

	localparam int MAX_LINES = 64;
	localparam int COLS = 7;

	logic                 mem_ui_clk;
	logic                 rst;
	wb_req_t              ch_req [NUM_CH];
	wb_resp_t             ch_resp [NUM_CH];
	logic                 app_rdy;
	logic                 app_wdf_rdy;
	logic                 app_rd_data_valid;
	logic [DATA_W-1:0]    app_rd_data;
	logic                 app_en;
	logic                 app_wdf_wren;
	logic                 app_wdf_end;
	app_cmd_e             app_cmd;
	logic [APP_ADR_W-1:0] app_addr;
	logic [DATA_W-1:0]    app_wdf_data;
	logic [SEL_W-1:0]     app_wdf_mask;

	logic [DATA_W-1:0] vec [MAX_LINES*COLS];
	int                num_lines;
	int                cycles;
	int                limit;
	int                cur_line;
	int                line_of [NUM_CH];
	logic [NUM_CH-1:0] busy;
	app_req_t          cmd_prev;
	app_wdf_t          wdf_prev;

	mpmc_top mpmc_top_inst (.*);
	mem_model mem_model_inst (.*);

	always #20 mem_ui_clk = ~mem_ui_clk;

	// ==============================
	// expected values
	// ==============================

	// columns: round, channel, op, address, sel, write data, read data
	function automatic logic [DATA_W-1:0] col(input int line, input int c);
		return vec[line*COLS + c];
	endfunction

	function automatic app_req_t expected_cmd(input int line);
		app_req_t         c;
		logic [ADR_W-1:0] a;
		a = ADR_W'(col(line, 3));
		c.en = 1'b1;
		c.cmd = (col(line, 2) != '0) ? APP_WRITE : APP_READ;
		c.addr = APP_ADR_W'({a[ADR_W-1:4], 4'h0});
		return c;
	endfunction

	// mask is the inverse of sel, unselected lanes go out as ff
	function automatic app_wdf_t expected_wdf(input int line);
		app_wdf_t         w;
		logic [SEL_W-1:0] s;
		s = SEL_W'(col(line, 4));
		w.wren = 1'b1;
		w.last = 1'b1;
		w.mask = ~s;
		w.data = col(line, 5);
		for (int b = 0; b < SEL_W; b++) begin
			if (!s[b])
				w.data[b*8 +: 8] = 8'hff;
		end
		return w;
	endfunction

	// ==============================
	// checks
	// ==============================

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic compare_cmd(input app_req_t got, input app_req_t exp, input string what);
		if (got.en !== exp.en || (exp.en && (got.cmd !== exp.cmd || got.addr !== exp.addr)))
			abort_run($sformatf("** Error at %0t ns: %s command got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic compare_wdf(input app_wdf_t got, input app_wdf_t exp, input string what);
		if (got.wren !== exp.wren || got.last !== exp.last ||
				(exp.wren && (got.data !== exp.data || got.mask !== exp.mask)))
			abort_run($sformatf("** Error at %0t ns: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic compare_resp(input wb_resp_t got, input wb_resp_t exp, input logic check_dat,
			input int ch);
		if (got.ack !== exp.ack || (check_dat && got.dat !== exp.dat))
			abort_run($sformatf("** Error at %0t ns: channel %0d response got %h expected %h",
				$time, ch, got, exp));
	endtask

	// one look at the memory port and the channels, once per falling edge
	task automatic watch_bus();
		app_req_t cmd_now;
		app_wdf_t wdf_now;
		wb_resp_t exp_resp;
		int       hit;
		cmd_now = '{en: app_en, cmd: app_cmd, addr: app_addr};
		wdf_now = '{wren: app_wdf_wren, last: app_wdf_end, data: app_wdf_data,
			mask: app_wdf_mask};
		if (busy == '0) begin
			compare_cmd(cmd_now, '0, "idle");
			compare_wdf(wdf_now, '0, "idle write data");
		end
		// app_rdy here is still the value the last rising edge saw
		if (cmd_prev.en && !app_rdy)
			compare_cmd(cmd_now, cmd_prev, "stalled");
		if (wdf_prev.wren && !app_wdf_rdy)
			compare_wdf(wdf_now, wdf_prev, "stalled write data");
		if (cmd_prev.en && app_rdy) begin
			hit = -1;
			for (int c = 0; c < NUM_CH; c++) begin
				if (busy[c] && expected_cmd(line_of[c]) === cmd_prev)
					hit = line_of[c];
			end
			if (hit < 0)
				abort_run($sformatf("** Error at %0t ns: command %h matches no open request",
					$time, cmd_prev));
			cur_line = hit;
		end
		if (wdf_now.wren)
			compare_wdf(wdf_now, expected_wdf(cur_line), "write data");
		for (int c = 0; c < NUM_CH; c++) begin
			if (ch_resp[c].ack) begin
				if (!busy[c])
					abort_run($sformatf("** Error at %0t ns: ack on idle channel %0d", $time, c));
				exp_resp.ack = 1'b1;
				exp_resp.dat = col(line_of[c], 6);
				compare_resp(ch_resp[c], exp_resp, col(line_of[c], 2) == '0, c);
				ch_req[c].cyc = 1'b0;
				ch_req[c].stb = 1'b0;
				busy[c] = 1'b0;
			end
		end
		cmd_prev = cmd_now;
		wdf_prev = wdf_now;
	endtask

	task automatic start_req(input int line);
		int c;
		c = int'(col(line, 1));
		ch_req[c] = '{cyc: 1'b1, stb: 1'b1, we: (col(line, 2) != '0),
			adr: ADR_W'(col(line, 3)), sel: SEL_W'(col(line, 4)), dat: col(line, 5)};
		line_of[c] = line;
		busy[c] = 1'b1;
	endtask

	always @(posedge mem_ui_clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
			abort_run($sformatf("timeout after %0d cycles with requests still open", cycles));
	end

	// ==============================
	// main sequence
	// ==============================

	initial begin
		int n;
		int round;
		mem_ui_clk = 1'b0;
		rst = 1'b1;
		cycles = 0;
		limit = 0;
		busy = '0;
		cur_line = 0;
		cmd_prev = '0;
		wdf_prev = '0;
		for (int c = 0; c < NUM_CH; c++) begin
			ch_req[c] = '0;
			line_of[c] = 0;
		end
		for (int i = 0; i < MAX_LINES*COLS; i++)
			vec[i] = '1;
		$readmemh("tests/mpmc_input.txt", vec);
		num_lines = 0;
		while (num_lines < MAX_LINES && vec[num_lines*COLS] != '1)
			num_lines++;
		if (num_lines == 0)
			abort_run("the input file holds no transactions");
		limit = num_lines * 64 + 100;
		repeat (4) @(negedge mem_ui_clk);
		rst = 1'b0;
		repeat (3) begin
			@(negedge mem_ui_clk);
			watch_bus();
		end
		n = 0;
		while (n < num_lines) begin
			round = int'(col(n, 0));
			while (n < num_lines && int'(col(n, 0)) == round) begin
				start_req(n);
				n++;
			end
			do begin
				@(negedge mem_ui_clk);
				watch_bus();
			end while (busy != '0);
			// one cycle with stb low so the next strobe is a new edge
			@(negedge mem_ui_clk);
			watch_bus();
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
source/mpmc_wb_pkg.sv
source/mpmc_app_pkg.sv
source/mpmc_req_arbiter.sv
source/mpmc_req_fifo.sv
source/mpmc_mem_sequencer.sv
source/mpmc_resp_router.sv
source/mpmc_top.sv
tests/mem_model.sv
tests/mpmc_tb.sv

/* tests/mpmc_input.txt */
// round channel op(1 write, 0 read) address sel write_data expected_read_data, all hex
// lines with the same round number start together, each on its own channel
1 0 1 00000100 ffff 00112233445566778899aabbccddeeff 0
2 0 0 00000100 ffff 0 00112233445566778899aabbccddeeff
3 1 1 00001230 ffff aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa 0
4 1 1 0000123c 0ff0 112233445566778899aabbccddeeff00 0
5 1 0 00001238 ffff 0 aaaaaaaa5566778899aabbccaaaaaaaa
6 0 1 00002010 ffff 10101010202020203030303040404040 0
6 1 1 00003020 ffff 0f0f0f0ff0f0f0f05a5a5a5aa5a5a5a5 0
6 2 1 00004030 f00f 0123456789abcdeffedcba9876543210 0
6 3 1 00005040 ffff deadbeefcafef00d0102030405060708 0
7 3 0 00005040 ffff 0 deadbeefcafef00d0102030405060708
7 2 0 00004030 ffff 0 01234567000000000000000076543210
7 1 0 00003020 ffff 0 0f0f0f0ff0f0f0f05a5a5a5aa5a5a5a5
7 0 0 00002010 ffff 0 10101010202020203030303040404040
8 2 0 00000100 ffff 0 00112233445566778899aabbccddeeff
8 3 0 00009990 ffff 0 00000000000000000000000000000000
8 0 1 0000123f 8001 c3000000000000000000000000000096 0
9 1 0 00001234 ffff 0 c3aaaaaa5566778899aabbccaaaaaa96
